// File: build.f
common/rv_exec_pkg.sv
hw/insn_decode.sv
hw/int_alu.sv
hw/branch_unit.sv
hw/exec_regs.sv
hw/exec_unit.sv
sim/tb_exec_unit.sv

// File: common/rv_exec_pkg.sv
package rv_exec_pkg;

  // rv64i datapath width
  localparam int XLEN = 64;

  // operands, pc, immediate and results
  typedef logic [XLEN-1:0] xlen_t;
  // low half used by the word ops
  typedef logic [31:0]     word_t;
  typedef logic [31:0]     insn_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      funct7_t;
  // 6 bits covers every 64-bit shift
  typedef logic [5:0]      shamt_t;

  // major opcodes handled by the execute stage
  localparam opcode_t OPC_OP        = 7'b0110011;
  localparam opcode_t OPC_OP_IMM    = 7'b0010011;
  localparam opcode_t OPC_OP_32     = 7'b0111011;
  localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
  localparam opcode_t OPC_AUIPC     = 7'b0010111;
  localparam opcode_t OPC_BRANCH    = 7'b1100011;
  localparam opcode_t OPC_JAL       = 7'b1101111;
  localparam opcode_t OPC_JALR      = 7'b1100111;

  // alu funct3, sub and sra share add and sr
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // branch funct3, 010 and 011 unused
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // funct7, alt has bit 30 of the insn set
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

  // return address step for jal/jalr
  localparam xlen_t LINK_OFFSET = 64'd4;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // none also marks an unsupported encoding
  typedef enum logic [3:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JAL,
    BR_JALR
  } br_cond_t;

  typedef enum logic {
    DEST_ALU,
    DEST_LINK
  } dest_sel_t;

endpackage

// File: hw/branch_unit.sv
module branch_unit (
  input  rv_exec_pkg::br_cond_t br_cond,
  input  rv_exec_pkg::xlen_t    pc,
  input  rv_exec_pkg::xlen_t    src1,
  input  rv_exec_pkg::xlen_t    src2,
  input  rv_exec_pkg::xlen_t    sign_ext,
  output logic                  taken,
  output rv_exec_pkg::xlen_t    target,
  output rv_exec_pkg::xlen_t    link
);

  logic               eq;
  logic               lt;
  logic               ltu;
  logic               is_jalr;
  rv_exec_pkg::xlen_t base;
  rv_exec_pkg::xlen_t sum;

  // one comparator set shared by all six conditions
  assign eq  = (src1 == src2);
  assign lt  = $signed(src1) < $signed(src2);
  assign ltu = src1 < src2;

  always_comb begin
    case (br_cond)
      rv_exec_pkg::BR_EQ:   taken = eq;
      rv_exec_pkg::BR_NE:   taken = !eq;
      rv_exec_pkg::BR_LT:   taken = lt;
      rv_exec_pkg::BR_GE:   taken = !lt;
      rv_exec_pkg::BR_LTU:  taken = ltu;
      rv_exec_pkg::BR_GEU:  taken = !ltu;
      // jumps always redirect
      rv_exec_pkg::BR_JAL:  taken = 1'b1;
      rv_exec_pkg::BR_JALR: taken = 1'b1;
      default:              taken = 1'b0;
    endcase
  end

  // jalr is register relative, everything else pc relative
  assign is_jalr = (br_cond == rv_exec_pkg::BR_JALR);
  assign base    = is_jalr ? src1 : pc;
  assign sum     = base + sign_ext;

  // jalr drops bit 0 of the sum
  assign target = is_jalr ? {sum[rv_exec_pkg::XLEN-1:1], 1'b0} : sum;

  // return address for jal/jalr
  assign link = pc + rv_exec_pkg::LINK_OFFSET;

endmodule

// File: hw/exec_regs.sv
module exec_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   insn_valid,
  input  logic                   dest_wr,
  input  rv_exec_pkg::dest_sel_t dest_sel,
  input  logic                   word_op,
  input  rv_exec_pkg::xlen_t     alu_result,
  input  rv_exec_pkg::xlen_t     link,
  input  logic                   taken,
  input  rv_exec_pkg::xlen_t     target,
  output logic                   dest_valid,
  output logic                   dest_long,
  output rv_exec_pkg::xlen_t     dest,
  output logic                   branch_target_valid,
  output rv_exec_pkg::xlen_t     branch_target
);

  rv_exec_pkg::xlen_t dest_next;

  // jumps write the return address
  assign dest_next = (dest_sel == rv_exec_pkg::DEST_LINK) ? link : alu_result;

  // strobes, one cycle per accepted insn
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dest_valid          <= 1'b0;
      branch_target_valid <= 1'b0;
    end else begin
      dest_valid          <= insn_valid && dest_wr;
      branch_target_valid <= insn_valid && taken;
    end
  end

  // payload loads every cycle, only meaningful with its strobe
  always_ff @(posedge clk) begin
    dest          <= dest_next;
    dest_long     <= ~word_op;
    branch_target <= target;
  end

  // an idle cycle never produces a write or redirect
  a_idle_quiet: assert property (
    @(posedge clk) disable iff (!rst_n)
    !insn_valid |=> !dest_valid && !branch_target_valid
  ) else $error("valid strobe after idle cycle");

  // strobes stay known once out of reset
  a_valids_known: assert property (
    @(posedge clk) rst_n |-> !$isunknown({dest_valid, branch_target_valid})
  ) else $error("unknown valid strobe");

endmodule

// File: hw/exec_unit.sv
module exec_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               insn_valid,
  input  rv_exec_pkg::insn_t insn,
  input  rv_exec_pkg::xlen_t pc,
  input  rv_exec_pkg::xlen_t sign_ext,
  input  rv_exec_pkg::xlen_t src1,
  input  rv_exec_pkg::xlen_t src2,
  output logic               dest_valid,
  output logic               dest_long,
  output rv_exec_pkg::xlen_t dest,
  output logic               branch_target_valid,
  output rv_exec_pkg::xlen_t branch_target
);

  // decode controls
  rv_exec_pkg::alu_op_t   alu_op;
  logic                   op_a_pc;
  logic                   op_b_imm;
  logic                   word_op;
  logic                   dest_wr;
  rv_exec_pkg::dest_sel_t dest_sel;
  rv_exec_pkg::br_cond_t  br_cond;

  // datapath results
  rv_exec_pkg::xlen_t     alu_result;
  logic                   taken;
  rv_exec_pkg::xlen_t     target;
  rv_exec_pkg::xlen_t     link;

  insn_decode u_decode (
    .insn     (insn),
    .alu_op   (alu_op),
    .op_a_pc  (op_a_pc),
    .op_b_imm (op_b_imm),
    .word_op  (word_op),
    .dest_wr  (dest_wr),
    .dest_sel (dest_sel),
    .br_cond  (br_cond)
  );

  int_alu u_alu (
    .alu_op     (alu_op),
    .op_a_pc    (op_a_pc),
    .op_b_imm   (op_b_imm),
    .word_op    (word_op),
    .pc         (pc),
    .src1       (src1),
    .src2       (src2),
    .sign_ext   (sign_ext),
    .alu_result (alu_result)
  );

  branch_unit u_branch (
    .br_cond  (br_cond),
    .pc       (pc),
    .src1     (src1),
    .src2     (src2),
    .sign_ext (sign_ext),
    .taken    (taken),
    .target   (target),
    .link     (link)
  );

  // single register stage, one cycle latency
  exec_regs u_regs (
    .clk                 (clk),
    .rst_n               (rst_n),
    .insn_valid          (insn_valid),
    .dest_wr             (dest_wr),
    .dest_sel            (dest_sel),
    .word_op             (word_op),
    .alu_result          (alu_result),
    .link                (link),
    .taken               (taken),
    .target              (target),
    .dest_valid          (dest_valid),
    .dest_long           (dest_long),
    .dest                (dest),
    .branch_target_valid (branch_target_valid),
    .branch_target       (branch_target)
  );

endmodule

// File: hw/insn_decode.sv
module insn_decode (
  input  rv_exec_pkg::insn_t     insn,
  output rv_exec_pkg::alu_op_t   alu_op,
  output logic                   op_a_pc,
  output logic                   op_b_imm,
  output logic                   word_op,
  output logic                   dest_wr,
  output rv_exec_pkg::dest_sel_t dest_sel,
  output rv_exec_pkg::br_cond_t  br_cond
);

  rv_exec_pkg::opcode_t opcode;
  rv_exec_pkg::funct3_t funct3;
  rv_exec_pkg::funct7_t funct7;
  logic [5:0]           funct6;

  // instruction fields
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  // rv64 immediate shifts use bit 25 as shamt[5]
  assign funct6 = insn[31:26];

  // funct3 to alu op for the base-funct7 forms
  function automatic rv_exec_pkg::alu_op_t base_op(input rv_exec_pkg::funct3_t f3);
    case (f3)
      rv_exec_pkg::F3_ADD:  base_op = rv_exec_pkg::ALU_ADD;
      rv_exec_pkg::F3_SLL:  base_op = rv_exec_pkg::ALU_SLL;
      rv_exec_pkg::F3_SLT:  base_op = rv_exec_pkg::ALU_SLT;
      rv_exec_pkg::F3_SLTU: base_op = rv_exec_pkg::ALU_SLTU;
      rv_exec_pkg::F3_XOR:  base_op = rv_exec_pkg::ALU_XOR;
      rv_exec_pkg::F3_SR:   base_op = rv_exec_pkg::ALU_SRL;
      rv_exec_pkg::F3_OR:   base_op = rv_exec_pkg::ALU_OR;
      // only f3_and is left
      default:              base_op = rv_exec_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    // defaults describe an unsupported encoding
    alu_op   = rv_exec_pkg::ALU_ADD;
    op_a_pc  = 1'b0;
    op_b_imm = 1'b0;
    word_op  = 1'b0;
    dest_wr  = 1'b0;
    dest_sel = rv_exec_pkg::DEST_ALU;
    br_cond  = rv_exec_pkg::BR_NONE;

    case (opcode)
      rv_exec_pkg::OPC_OP: begin
        if (funct7 == rv_exec_pkg::F7_BASE) begin
          alu_op  = base_op(funct3);
          dest_wr = 1'b1;
        end else if (funct7 == rv_exec_pkg::F7_ALT) begin
          // alt funct7 only exists for sub and sra
          if (funct3 == rv_exec_pkg::F3_ADD) begin
            alu_op  = rv_exec_pkg::ALU_SUB;
            dest_wr = 1'b1;
          end else if (funct3 == rv_exec_pkg::F3_SR) begin
            alu_op  = rv_exec_pkg::ALU_SRA;
            dest_wr = 1'b1;
          end
        end
      end
      rv_exec_pkg::OPC_OP_IMM: begin
        op_b_imm = 1'b1;
        if (funct3 == rv_exec_pkg::F3_SLL) begin
          alu_op  = rv_exec_pkg::ALU_SLL;
          dest_wr = (funct6 == 6'b000000);
        end else if (funct3 == rv_exec_pkg::F3_SR) begin
          // bit 30 picks arithmetic, rest of funct6 must be zero
          if (insn[30]) begin
            alu_op = rv_exec_pkg::ALU_SRA;
          end else begin
            alu_op = rv_exec_pkg::ALU_SRL;
          end
          dest_wr = ({funct6[5], funct6[3:0]} == 5'b00000);
        end else begin
          alu_op  = base_op(funct3);
          dest_wr = 1'b1;
        end
      end
      rv_exec_pkg::OPC_OP_32: begin
        word_op = 1'b1;
        // no slt or logic ops in the word space
        if (funct7 == rv_exec_pkg::F7_BASE &&
            funct3 inside {rv_exec_pkg::F3_ADD, rv_exec_pkg::F3_SLL, rv_exec_pkg::F3_SR}) begin
          alu_op  = base_op(funct3);
          dest_wr = 1'b1;
        end else if (funct7 == rv_exec_pkg::F7_ALT && funct3 == rv_exec_pkg::F3_ADD) begin
          alu_op  = rv_exec_pkg::ALU_SUB;
          dest_wr = 1'b1;
        end else if (funct7 == rv_exec_pkg::F7_ALT && funct3 == rv_exec_pkg::F3_SR) begin
          alu_op  = rv_exec_pkg::ALU_SRA;
          dest_wr = 1'b1;
        end
      end
      rv_exec_pkg::OPC_OP_IMM_32: begin
        word_op  = 1'b1;
        op_b_imm = 1'b1;
        if (funct3 == rv_exec_pkg::F3_ADD) begin
          dest_wr = 1'b1;
        end else if (funct3 == rv_exec_pkg::F3_SLL && funct7 == rv_exec_pkg::F7_BASE) begin
          alu_op  = rv_exec_pkg::ALU_SLL;
          dest_wr = 1'b1;
        end else if (funct3 == rv_exec_pkg::F3_SR && funct7 == rv_exec_pkg::F7_BASE) begin
          alu_op  = rv_exec_pkg::ALU_SRL;
          dest_wr = 1'b1;
        end else if (funct3 == rv_exec_pkg::F3_SR && funct7 == rv_exec_pkg::F7_ALT) begin
          alu_op  = rv_exec_pkg::ALU_SRA;
          dest_wr = 1'b1;
        end
      end
      rv_exec_pkg::OPC_AUIPC: begin
        // pc plus the u-immediate
        op_a_pc  = 1'b1;
        op_b_imm = 1'b1;
        dest_wr  = 1'b1;
      end
      rv_exec_pkg::OPC_BRANCH: begin
        case (funct3)
          rv_exec_pkg::F3_BEQ:  br_cond = rv_exec_pkg::BR_EQ;
          rv_exec_pkg::F3_BNE:  br_cond = rv_exec_pkg::BR_NE;
          rv_exec_pkg::F3_BLT:  br_cond = rv_exec_pkg::BR_LT;
          rv_exec_pkg::F3_BGE:  br_cond = rv_exec_pkg::BR_GE;
          rv_exec_pkg::F3_BLTU: br_cond = rv_exec_pkg::BR_LTU;
          rv_exec_pkg::F3_BGEU: br_cond = rv_exec_pkg::BR_GEU;
          default:              br_cond = rv_exec_pkg::BR_NONE;
        endcase
      end
      rv_exec_pkg::OPC_JAL: begin
        dest_wr  = 1'b1;
        dest_sel = rv_exec_pkg::DEST_LINK;
        br_cond  = rv_exec_pkg::BR_JAL;
      end
      rv_exec_pkg::OPC_JALR: begin
        // jalr is only defined with funct3 zero
        if (funct3 == 3'b000) begin
          dest_wr  = 1'b1;
          dest_sel = rv_exec_pkg::DEST_LINK;
          br_cond  = rv_exec_pkg::BR_JALR;
        end
      end
      default: begin
        dest_wr = 1'b0;
      end
    endcase
  end

endmodule

// File: hw/int_alu.sv
module int_alu (
  input  rv_exec_pkg::alu_op_t alu_op,
  input  logic                 op_a_pc,
  input  logic                 op_b_imm,
  input  logic                 word_op,
  input  rv_exec_pkg::xlen_t   pc,
  input  rv_exec_pkg::xlen_t   src1,
  input  rv_exec_pkg::xlen_t   src2,
  input  rv_exec_pkg::xlen_t   sign_ext,
  output rv_exec_pkg::xlen_t   alu_result
);

  rv_exec_pkg::xlen_t  op_a;
  rv_exec_pkg::xlen_t  op_b;
  rv_exec_pkg::xlen_t  sum;
  rv_exec_pkg::xlen_t  diff;
  rv_exec_pkg::xlen_t  res_long;
  rv_exec_pkg::word_t  a_w;
  rv_exec_pkg::word_t  res_w;
  rv_exec_pkg::shamt_t shamt;
  logic                lt;
  logic                ltu;

  // operand a is pc only for auipc
  assign op_a = op_a_pc ? pc : src1;
  assign op_b = op_b_imm ? sign_ext : src2;

  // word shifts ignore bit 5 of the amount
  assign shamt = word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;
  assign lt   = $signed(op_a) < $signed(op_b);
  assign ltu  = op_a < op_b;

  // low half for word shifts
  assign a_w = op_a[31:0];

  // full 64-bit results
  always_comb begin
    case (alu_op)
      rv_exec_pkg::ALU_ADD:  res_long = sum;
      rv_exec_pkg::ALU_SUB:  res_long = diff;
      rv_exec_pkg::ALU_SLL:  res_long = op_a << shamt;
      rv_exec_pkg::ALU_SRL:  res_long = op_a >> shamt;
      rv_exec_pkg::ALU_SRA:  res_long = $signed(op_a) >>> shamt;
      rv_exec_pkg::ALU_SLT:  res_long = {{(rv_exec_pkg::XLEN-1){1'b0}}, lt};
      rv_exec_pkg::ALU_SLTU: res_long = {{(rv_exec_pkg::XLEN-1){1'b0}}, ltu};
      rv_exec_pkg::ALU_XOR:  res_long = op_a ^ op_b;
      rv_exec_pkg::ALU_OR:   res_long = op_a | op_b;
      rv_exec_pkg::ALU_AND:  res_long = op_a & op_b;
      default:               res_long = sum;
    endcase
  end

  // word results, right shifts fill from bit 31 not bit 63
  always_comb begin
    case (alu_op)
      rv_exec_pkg::ALU_SUB: res_w = diff[31:0];
      rv_exec_pkg::ALU_SLL: res_w = a_w << shamt;
      rv_exec_pkg::ALU_SRL: res_w = a_w >> shamt;
      rv_exec_pkg::ALU_SRA: res_w = $signed(a_w) >>> shamt;
      // addw/addiw, low half of the sum is exact
      default:              res_w = sum[31:0];
    endcase
  end

  // word ops sign-extend bit 31
  assign alu_result = word_op ? {{32{res_w[31]}}, res_w} : res_long;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the exec_unit testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_exec_unit \
  -Mdir obj_dir -o sim_exec_unit

# the log decides pass or fail, not the exit code
./obj_dir/sim_exec_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: sim/tb_exec_unit.sv
module tb_exec_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 5;
  localparam int N_RR       = 40;
  localparam int N_IMM      = 60;
  localparam int N_BR       = 36;
  localparam int N_JMP      = 20;
  localparam int N_MIX      = 40;
  localparam int N_TESTS    = 6;
  localparam int MARGIN     = 20;
  // every vector is one cycle, each test adds one trailing idle
  localparam int N_VEC      = RST_CYCLES + N_RR + N_IMM + N_BR + N_JMP + N_MIX + N_TESTS;
  localparam int WDOG_NS    = (N_VEC + MARGIN) * CLK_PERIOD;

  localparam rv_exec_pkg::funct3_t BR_F3 [6] = '{rv_exec_pkg::F3_BEQ, rv_exec_pkg::F3_BNE,
    rv_exec_pkg::F3_BLT, rv_exec_pkg::F3_BGE, rv_exec_pkg::F3_BLTU, rv_exec_pkg::F3_BGEU};
  // load, store, lui, system are outside this stage
  localparam rv_exec_pkg::opcode_t BAD_OPC [4] = '{7'b0000011, 7'b0100011, 7'b0110111,
    7'b1110011};

  logic               clk;
  logic               rst_n;
  logic               insn_valid;
  rv_exec_pkg::insn_t insn;
  rv_exec_pkg::xlen_t pc;
  rv_exec_pkg::xlen_t sign_ext;
  rv_exec_pkg::xlen_t src1;
  rv_exec_pkg::xlen_t src2;
  logic               dest_valid;
  logic               dest_long;
  rv_exec_pkg::xlen_t dest;
  logic               branch_target_valid;
  rv_exec_pkg::xlen_t branch_target;

  // expected outputs, set with the stimulus on the falling edge
  logic               exp_dv;
  logic               exp_long;
  logic               exp_btv;
  rv_exec_pkg::xlen_t exp_dest;
  rv_exec_pkg::xlen_t exp_tgt;
  // same values one stage later, lined up with the dut outputs
  logic               chk_armed = 1'b0;
  logic               chk_dv    = 1'b0;
  logic               chk_long  = 1'b0;
  logic               chk_btv   = 1'b0;
  rv_exec_pkg::xlen_t chk_dest  = '0;
  rv_exec_pkg::xlen_t chk_tgt   = '0;

  int seed = 32'h92c2dd2a;
  int err_count  = 0;
  int err_mark   = 0;
  int test_count = 0;

  exec_unit DUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .insn_valid          (insn_valid),
    .insn                (insn),
    .pc                  (pc),
    .sign_ext            (sign_ext),
    .src1                (src1),
    .src2                (src2),
    .dest_valid          (dest_valid),
    .dest_long           (dest_long),
    .dest                (dest),
    .branch_target_valid (branch_target_valid),
    .branch_target       (branch_target)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // run-length guard
  initial begin
    #(WDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("FAIL: see errors above");
    $finish;
  end

  always @(posedge clk) begin
    chk_armed <= 1'b1;
    chk_dv    <= exp_dv;
    chk_long  <= exp_long;
    chk_btv   <= exp_btv;
    chk_dest  <= exp_dest;
    chk_tgt   <= exp_tgt;
  end

  task automatic flag_mismatch(input string sig, input logic [63:0] got,
                               input logic [63:0] want);
    err_count++;
    $display("[ERROR] %s got 0x%h expected 0x%h at %0t", sig, got, want, $time);
  endtask

  // strobes checked every cycle, payload only under its strobe
  a_dest_valid: assert property (@(posedge clk) chk_armed |-> (dest_valid == chk_dv))
    else flag_mismatch("dest_valid", {63'd0, $sampled(dest_valid)}, {63'd0, $sampled(chk_dv)});
  a_btv: assert property (@(posedge clk) chk_armed |-> (branch_target_valid == chk_btv))
    else flag_mismatch("branch_target_valid", {63'd0, $sampled(branch_target_valid)},
                       {63'd0, $sampled(chk_btv)});
  a_dest: assert property (@(posedge clk) (chk_armed && chk_dv) |-> (dest == chk_dest))
    else flag_mismatch("dest", $sampled(dest), $sampled(chk_dest));
  a_dest_long: assert property (@(posedge clk) (chk_armed && chk_dv) |-> (dest_long == chk_long))
    else flag_mismatch("dest_long", {63'd0, $sampled(dest_long)}, {63'd0, $sampled(chk_long)});
  a_target: assert property (@(posedge clk) (chk_armed && chk_btv) |-> (branch_target == chk_tgt))
    else flag_mismatch("branch_target", $sampled(branch_target), $sampled(chk_tgt));

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  function automatic rv_exec_pkg::xlen_t rand64();
    rand64 = {rand32(), rand32()};
  endfunction

  // word aligned pc
  function automatic rv_exec_pkg::xlen_t rand_pc();
    rand_pc = rand64() & ~64'h3;
  endfunction

  function automatic rv_exec_pkg::insn_t enc_r(input rv_exec_pkg::funct7_t f7,
      input rv_exec_pkg::funct3_t f3, input rv_exec_pkg::opcode_t opc);
    enc_r = {f7, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic rv_exec_pkg::insn_t enc_i(input logic [11:0] imm,
      input rv_exec_pkg::funct3_t f3, input rv_exec_pkg::opcode_t opc);
    enc_i = {imm, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic rv_exec_pkg::insn_t enc_b(input logic [12:0] imm,
      input rv_exec_pkg::funct3_t f3);
    enc_b = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], rv_exec_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_exec_pkg::insn_t enc_j(input logic [20:0] imm);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, rv_exec_pkg::OPC_JAL};
  endfunction

  // rv64i integer semantics, word forms on the low half
  function automatic rv_exec_pkg::xlen_t alu_ref(input rv_exec_pkg::funct3_t f3,
      input logic alt, input logic word, input rv_exec_pkg::xlen_t a,
      input rv_exec_pkg::xlen_t b);
    logic [5:0]  sh;
    logic [31:0] w;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    if (word) begin
      case (f3)
        rv_exec_pkg::F3_SLL: w = a[31:0] << sh;
        rv_exec_pkg::F3_SR: begin
          // sraw fills from bit 31
          if (alt) begin
            w = $signed(a[31:0]) >>> sh;
          end else begin
            w = a[31:0] >> sh;
          end
        end
        default:             w = alt ? (a[31:0] - b[31:0]) : (a[31:0] + b[31:0]);
      endcase
      alu_ref = {{32{w[31]}}, w};
    end else begin
      case (f3)
        rv_exec_pkg::F3_ADD:  alu_ref = alt ? (a - b) : (a + b);
        rv_exec_pkg::F3_SLL:  alu_ref = a << sh;
        rv_exec_pkg::F3_SLT:  alu_ref = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        rv_exec_pkg::F3_SLTU: alu_ref = (a < b) ? 64'd1 : 64'd0;
        rv_exec_pkg::F3_XOR:  alu_ref = a ^ b;
        rv_exec_pkg::F3_SR: begin
          if (alt) begin
            alu_ref = $signed(a) >>> sh;
          end else begin
            alu_ref = a >> sh;
          end
        end
        rv_exec_pkg::F3_OR:   alu_ref = a | b;
        default:              alu_ref = a & b;
      endcase
    end
  endfunction

  function automatic logic br_ref(input rv_exec_pkg::funct3_t f3,
      input rv_exec_pkg::xlen_t a, input rv_exec_pkg::xlen_t b);
    case (f3)
      rv_exec_pkg::F3_BEQ:  br_ref = (a == b);
      rv_exec_pkg::F3_BNE:  br_ref = (a != b);
      rv_exec_pkg::F3_BLT:  br_ref = ($signed(a) < $signed(b));
      rv_exec_pkg::F3_BGE:  br_ref = ($signed(a) >= $signed(b));
      rv_exec_pkg::F3_BLTU: br_ref = (a < b);
      default:              br_ref = (a >= b);
    endcase
  endfunction

  // one valid instruction on this falling edge
  task automatic drive(input rv_exec_pkg::insn_t iw, input rv_exec_pkg::xlen_t pc_v,
      input rv_exec_pkg::xlen_t imm_v, input rv_exec_pkg::xlen_t a,
      input rv_exec_pkg::xlen_t b, input logic dv, input rv_exec_pkg::xlen_t d,
      input logic lng, input logic btv, input rv_exec_pkg::xlen_t tgt);
    insn_valid = 1'b1;
    insn       = iw;
    pc         = pc_v;
    sign_ext   = imm_v;
    src1       = a;
    src2       = b;
    exp_dv     = dv;
    exp_dest   = d;
    exp_long   = lng;
    exp_btv    = btv;
    exp_tgt    = tgt;
    @(negedge clk);
  endtask

  // valid low, payload still looks like a taken jump
  task automatic idle_cycle();
    insn_valid = 1'b0;
    insn       = enc_j(21'h000100);
    pc         = rand_pc();
    sign_ext   = 64'h100;
    src1       = rand64();
    src2       = rand64();
    exp_dv     = 1'b0;
    exp_btv    = 1'b0;
    @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int n);
    idle_cycle();
    $display("test %-8s done, %0d vectors, %0d errors", name, n, err_count - err_mark);
    err_mark = err_count;
    test_count++;
  endtask

  task automatic test_reg_reg();
    logic [31:0]          r;
    logic                 word;
    logic                 alt;
    rv_exec_pkg::funct3_t f3;
    rv_exec_pkg::xlen_t   a;
    rv_exec_pkg::xlen_t   b;
    for (int i = 0; i < N_RR; i++) begin
      r    = rand32();
      word = i[0];
      alt  = r[1];
      f3   = r[4:2];
      a    = rand64();
      b    = rand64();
      // word space has only add/sub, sll, srl/sra
      if (word && !(f3 inside {rv_exec_pkg::F3_ADD, rv_exec_pkg::F3_SLL, rv_exec_pkg::F3_SR}))
        f3 = rv_exec_pkg::F3_ADD;
      if (!(f3 inside {rv_exec_pkg::F3_ADD, rv_exec_pkg::F3_SR}))
        alt = 1'b0;
      drive(enc_r(alt ? rv_exec_pkg::F7_ALT : rv_exec_pkg::F7_BASE, f3,
                  word ? rv_exec_pkg::OPC_OP_32 : rv_exec_pkg::OPC_OP),
            rand_pc(), rand64(), a, b, 1'b1, alu_ref(f3, alt, word, a, b), !word, 1'b0, 64'd0);
    end
    finish_test("reg_reg", N_RR);
  endtask

  task automatic test_imm();
    logic [31:0]          r;
    logic [11:0]          imm12;
    logic                 alt;
    rv_exec_pkg::funct3_t f3;
    rv_exec_pkg::xlen_t   a;
    rv_exec_pkg::xlen_t   imm;
    rv_exec_pkg::xlen_t   pc_v;
    for (int i = 0; i < N_IMM; i++) begin
      r     = rand32();
      a     = rand64();
      pc_v  = rand_pc();
      alt   = 1'b0;
      imm12 = r[31:20];
      case (i % 3)
        0: begin
          f3 = r[2:0];
          // 6-bit shamt, bit 30 picks srai
          if (f3 == rv_exec_pkg::F3_SLL) begin
            imm12 = {6'd0, r[25:20]};
          end else if (f3 == rv_exec_pkg::F3_SR) begin
            alt   = r[10];
            imm12 = {1'b0, alt, 4'd0, r[25:20]};
          end
          imm = {{52{imm12[11]}}, imm12};
          drive(enc_i(imm12, f3, rv_exec_pkg::OPC_OP_IMM), pc_v, imm, a, rand64(),
                1'b1, alu_ref(f3, alt, 1'b0, a, imm), 1'b1, 1'b0, 64'd0);
        end
        1: begin
          f3 = (r[1:0] == 2'd0) ? rv_exec_pkg::F3_ADD :
               (r[1:0] == 2'd1) ? rv_exec_pkg::F3_SLL : rv_exec_pkg::F3_SR;
          // word shifts take a 5-bit shamt
          if (f3 == rv_exec_pkg::F3_SLL) begin
            imm12 = {7'd0, r[24:20]};
          end else if (f3 == rv_exec_pkg::F3_SR) begin
            alt   = r[10];
            imm12 = {1'b0, alt, 5'd0, r[24:20]};
          end
          imm = {{52{imm12[11]}}, imm12};
          drive(enc_i(imm12, f3, rv_exec_pkg::OPC_OP_IMM_32), pc_v, imm, a, rand64(),
                1'b1, alu_ref(f3, alt, 1'b1, a, imm), 1'b0, 1'b0, 64'd0);
        end
        default: begin
          // auipc, u-immediate in the upper 20 bits
          imm = {{32{r[31]}}, r[31:12], 12'd0};
          drive({r[31:12], 5'd3, rv_exec_pkg::OPC_AUIPC}, pc_v, imm, a, rand64(),
                1'b1, pc_v + imm, 1'b1, 1'b0, 64'd0);
        end
      endcase
    end
    finish_test("imm", N_IMM);
  endtask

  task automatic test_branch();
    logic [31:0]        r;
    logic [12:0]        imm13;
    logic               tk;
    rv_exec_pkg::xlen_t x;
    rv_exec_pkg::xlen_t lo;
    rv_exec_pkg::xlen_t hi;
    rv_exec_pkg::xlen_t a;
    rv_exec_pkg::xlen_t b;
    rv_exec_pkg::xlen_t imm;
    rv_exec_pkg::xlen_t pc_v;
    for (int c = 0; c < 6; c++) begin
      for (int rel = 0; rel < 3; rel++) begin
        for (int sgn = 0; sgn < 2; sgn++) begin
          r    = rand32();
          pc_v = rand_pc();
          // top bits clear so the unsigned pair cannot wrap
          x    = rand64() >> 2;
          if (sgn == 1) begin
            // negative vs positive, signed and unsigned order disagree
            lo = x | 64'h8000_0000_0000_0000;
            hi = x;
          end else begin
            lo = x;
            hi = x + {32'd0, r} + 64'd1;
          end
          a = (rel == 2) ? hi : lo;
          b = (rel == 1) ? hi : lo;
          imm13 = {r[12:1], 1'b0};
          imm   = {{51{imm13[12]}}, imm13};
          tk    = br_ref(BR_F3[c], a, b);
          drive(enc_b(imm13, BR_F3[c]), pc_v, imm, a, b, 1'b0, 64'd0, 1'b1, tk, pc_v + imm);
        end
      end
    end
    finish_test("branch", N_BR);
  endtask

  task automatic test_jump();
    logic [31:0]        r;
    logic [20:0]        imm21;
    logic [11:0]        imm12;
    rv_exec_pkg::xlen_t a;
    rv_exec_pkg::xlen_t imm;
    rv_exec_pkg::xlen_t sum;
    rv_exec_pkg::xlen_t pc_v;
    for (int i = 0; i < N_JMP; i++) begin
      r    = rand32();
      a    = rand64();
      pc_v = rand_pc();
      if (!i[0]) begin
        imm21 = {r[20:1], 1'b0};
        imm   = {{43{imm21[20]}}, imm21};
        drive(enc_j(imm21), pc_v, imm, a, rand64(), 1'b1, pc_v + 64'd4, 1'b1, 1'b1, pc_v + imm);
      end else begin
        imm12 = r[31:20];
        imm   = {{52{imm12[11]}}, imm12};
        sum   = a + imm;
        // force an odd sum so the cleared bit 0 shows
        if (!sum[0]) begin
          a[0] = ~a[0];
          sum  = a + imm;
        end
        drive(enc_i(imm12, 3'b000, rv_exec_pkg::OPC_JALR), pc_v, imm, a, rand64(),
              1'b1, pc_v + 64'd4, 1'b1, 1'b1, {sum[63:1], 1'b0});
      end
    end
    finish_test("jump", N_JMP);
  endtask

  task automatic test_mix();
    logic [31:0]        r;
    rv_exec_pkg::xlen_t a;
    rv_exec_pkg::xlen_t b;
    for (int i = 0; i < N_MIX; i++) begin
      r = rand32();
      a = rand64();
      b = rand64();
      case (r[1:0])
        2'd0: idle_cycle();
        2'd1: drive({r[31:7], BAD_OPC[r[3:2]]}, rand_pc(), rand64(), a, b,
                    1'b0, 64'd0, 1'b0, 1'b0, 64'd0);
        // m-extension funct7 is illegal here
        2'd2: drive(enc_r(7'b0000001, r[14:12], rv_exec_pkg::OPC_OP), rand_pc(), rand64(),
                    a, b, 1'b0, 64'd0, 1'b0, 1'b0, 64'd0);
        default: drive(enc_r(rv_exec_pkg::F7_BASE, rv_exec_pkg::F3_ADD, rv_exec_pkg::OPC_OP),
                       rand_pc(), rand64(), a, b, 1'b1, a + b, 1'b1, 1'b0, 64'd0);
      endcase
    end
    finish_test("mix", N_MIX);
  endtask

  initial begin
    rst_n      = 1'b0;
    insn_valid = 1'b0;
    insn       = '0;
    pc         = '0;
    sign_ext   = '0;
    src1       = '0;
    src2       = '0;
    exp_dv     = 1'b0;
    exp_long   = 1'b0;
    exp_btv    = 1'b0;
    exp_dest   = '0;
    exp_tgt    = '0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    finish_test("reset", RST_CYCLES);
    test_reg_reg();
    test_imm();
    test_branch();
    test_jump();
    test_mix();
    $display("%0d tests run, %0d checks failed", test_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
